// ==== sources.f ====
src/stepper_pkg.sv
src/pulse_cfg_if.sv
src/stepper_regs.sv
src/speed_integrator.sv
src/endstop_filter.sv
src/step_router.sv
src/step_pulse_gen.sv
src/stepper_top.sv
testbench/stepper_sva.sv
testbench/tb_stepper_top.sv

// ==== testbench/tb_stepper_top.sv ====
`timescale 1ns/10ps

module tb_stepper_top;
    import stepper_pkg::*;

    typedef enum logic [3:0] {
        op_wr, op_wr_rnd, op_rd, op_rd_rnd, op_rd_pos, op_run,
        op_es, op_clr, op_moved, op_dir, op_en
    } tb_op_e;

    localparam int max_entries = 80;
    localparam int pulse_w     = 3;  // pulse register value written by the table

    logic        clk;
    logic        rst_n;
    logic        wr_stb;
    logic [7:0]  addr;
    logic [31:0] wdata;
    logic        rd_stb;
    logic [3:0]  endstop;
    logic        rd_valid;
    logic [31:0] rd_data;
    logic [3:0]  mot_step;
    logic [3:0]  mot_dir;
    logic [3:0]  mot_enable;

    tb_op_e      tbl_op   [max_entries];
    logic [7:0]  tbl_addr [max_entries];
    logic [31:0] tbl_data [max_entries];
    logic [31:0] tbl_exp  [max_entries];
    int          n_entries;

    integer      seed;
    logic [31:0] last_rnd;
    int          pulse_cnt [4];
    int          hi_len [4];
    logic [3:0]  step_prev;
    logic [31:0] pos_base;
    int          cycle_cnt;
    int          cycle_limit;
    int          sva_fails;

    stepper_top i_stepper_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_stb     (wr_stb),
        .addr       (addr),
        .wdata      (wdata),
        .rd_stb     (rd_stb),
        .endstop    (endstop),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .mot_step   (mot_step),
        .mot_dir    (mot_dir),
        .mot_enable (mot_enable)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("Test failures found");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic add_entry(input tb_op_e op, input logic [7:0] a,
                             input logic [31:0] d, input logic [31:0] e);
        tbl_op[n_entries]   = op;
        tbl_addr[n_entries] = a;
        tbl_data[n_entries] = d;
        tbl_exp[n_entries]  = e;
        n_entries++;
    endtask

    task automatic host_write(input logic [7:0] a, input logic [31:0] d);
        @(negedge clk);
        wr_stb = 1'b1;
        addr   = a;
        wdata  = d;
        @(negedge clk);
        wr_stb = 1'b0;
    endtask

    // rd_valid must be high for the one cycle after rd_stb only
    task automatic host_read(input logic [7:0] a, input logic [31:0] expected);
        @(negedge clk);
        rd_stb = 1'b1;
        addr   = a;
        @(negedge clk);
        rd_stb = 1'b0;
        check("rd_valid", rd_valid, 32'd1);
        check($sformatf("rd_data at 0x%02h", a), rd_data, expected);
        @(negedge clk);
        check("rd_valid", rd_valid, 32'd0);
    endtask

    task automatic build_table();
        add_entry(op_wr_rnd, addr_loopback, 0, 0);
        add_entry(op_rd_rnd, addr_loopback, 0, 0);
        add_entry(op_wr_rnd, addr_loopback, 0, 0);
        add_entry(op_rd_rnd, addr_loopback, 0, 0);
        add_entry(op_rd, 8'h3E, 0, 0);
        add_entry(op_rd, addr_cmd, 0, 0);
        // position load into motors 1 and 3
        add_entry(op_wr_rnd, addr_pos_val, 0, 0);
        add_entry(op_wr, addr_cmd, 32'h0A02, 0);
        add_entry(op_rd_rnd, addr_pos1, 0, 0);
        add_entry(op_rd_rnd, addr_pos3, 0, 0);
        add_entry(op_rd, addr_pos0, 0, 0);
        add_entry(op_rd, addr_pos2, 0, 0);
        add_entry(op_wr, addr_step_bit, 4, 0);
        add_entry(op_wr, addr_pre, 1, 0);
        add_entry(op_wr, addr_pulse, pulse_w, 0);
        add_entry(op_wr, addr_post, 1, 0);
        add_entry(op_rd, addr_pulse, 0, pulse_w);
        add_entry(op_wr, addr_motor_cfg0, 32'h50, 0);  // step_en, es_abort_en
        add_entry(op_wr, addr_motor_cfg1, 32'h00, 0);
        add_entry(op_wr, addr_motor_cfg2, 32'h80, 0);  // disabled
        add_entry(op_en, 0, 0, 32'hB);
        add_entry(op_clr, 0, 0, 0);
        add_entry(op_wr, addr_speed0, 4, 0);
        add_entry(op_wr, addr_cmd, 1, 0);
        add_entry(op_run, 0, 80, 0);
        add_entry(op_wr, addr_speed0, 0, 0);
        add_entry(op_wr, addr_cmd, 1, 0);
        add_entry(op_run, 0, 20, 0);
        add_entry(op_rd_pos, addr_pos0, 0, 0);
        add_entry(op_moved, 0, 0, 1);
        add_entry(op_moved, 0, 1, 0);
        add_entry(op_moved, 0, 2, 0);
        add_entry(op_dir, 0, 0, 0);
        // second run with inverted direction from a known start
        add_entry(op_wr, addr_pos_val, 32'h1000, 0);
        add_entry(op_wr, addr_cmd, 32'h0102, 0);
        add_entry(op_wr, addr_motor_cfg0, 32'h70, 0);
        add_entry(op_clr, 0, 32'h1000, 0);
        add_entry(op_wr, addr_speed0, 4, 0);
        add_entry(op_wr, addr_cmd, 1, 0);
        add_entry(op_run, 0, 80, 0);
        add_entry(op_wr, addr_speed0, 0, 0);
        add_entry(op_wr, addr_cmd, 1, 0);
        add_entry(op_run, 0, 20, 0);
        add_entry(op_rd_pos, addr_pos0, 0, 1);
        add_entry(op_moved, 0, 0, 1);
        add_entry(op_dir, 0, 0, 1);
        // endstop lock, hold and abort
        add_entry(op_wr, addr_motor_cfg0, 32'h50, 0);
        add_entry(op_wr, addr_es_timeout, 5, 0);
        add_entry(op_wr, addr_speed0, 4, 0);
        add_entry(op_wr, addr_cmd, 1, 0);
        add_entry(op_run, 0, 20, 0);
        add_entry(op_es, 0, 1, 0);
        add_entry(op_run, 0, 10, 0);
        add_entry(op_rd, addr_es_status, 0, 32'h11);
        add_entry(op_es, 0, 0, 0);
        add_entry(op_clr, 0, 0, 0);
        add_entry(op_run, 0, 20, 0);
        add_entry(op_moved, 0, 0, 0);
        add_entry(op_wr, addr_cmd, 4, 0);
        add_entry(op_rd, addr_es_status, 0, 0);
        add_entry(op_clr, 0, 0, 0);
        add_entry(op_run, 0, 20, 0);
        add_entry(op_moved, 0, 0, 0);  // channel 0 was aborted
        add_entry(op_wr, addr_cmd, 1, 0);
        add_entry(op_run, 0, 30, 0);
        add_entry(op_moved, 0, 0, 1);
        // short glitch below the timeout
        add_entry(op_es, 0, 1, 0);
        add_entry(op_run, 0, 3, 0);
        add_entry(op_es, 0, 0, 0);
        add_entry(op_run, 0, 10, 0);
        add_entry(op_rd, addr_es_status, 0, 0);
    endtask

    task automatic apply_entry(input int i);
        logic [31:0] expected;
        int          m;
        m = tbl_data[i][1:0];
        case (tbl_op[i])
            op_wr: host_write(tbl_addr[i], tbl_data[i]);
            op_wr_rnd: begin
                last_rnd = $random(seed);
                host_write(tbl_addr[i], last_rnd);
            end
            op_rd:     host_read(tbl_addr[i], tbl_exp[i]);
            op_rd_rnd: host_read(tbl_addr[i], last_rnd);
            op_rd_pos: begin
                @(posedge clk);
                m        = tbl_addr[i][1:0];  // motor number from the pos address
                expected = tbl_exp[i][0] ? pos_base - pulse_cnt[m] : pos_base + pulse_cnt[m];
                host_read(tbl_addr[i], expected);
            end
            op_run: repeat (tbl_data[i]) @(negedge clk);
            op_es: begin
                @(negedge clk);
                endstop = tbl_data[i][3:0];
            end
            op_clr: begin
                @(posedge clk);
                for (int k = 0; k < 4; k++) begin
                    pulse_cnt[k] = 0;
                end
                pos_base = tbl_data[i];
            end
            op_moved: begin
                @(posedge clk);
                check($sformatf("mot_step[%0d] pulses seen", m), pulse_cnt[m] != 0, tbl_exp[i]);
            end
            op_dir: begin
                @(negedge clk);
                check($sformatf("mot_dir[%0d]", m), mot_dir[m], tbl_exp[i]);
            end
            default: begin
                @(negedge clk);
                check("mot_enable", mot_enable, tbl_exp[i]);
            end
        endcase
    endtask

    // pulse counter and width check on every motor
    always @(negedge clk) begin
        for (int m = 0; m < 4; m++) begin
            if (mot_step[m] === 1'b1) begin
                if (!step_prev[m]) begin
                    pulse_cnt[m]++;
                end
                hi_len[m]++;
            end else if (step_prev[m]) begin
                check($sformatf("mot_step[%0d] width", m), hi_len[m], pulse_w);
                hi_len[m] = 0;
            end
        end
        step_prev = mot_step;
    end

    // failures of the bound pulse generator assertions
    always @(negedge clk) begin
        sva_fails = i_stepper_top.g_motor[0].i_step_pulse_gen.i_stepper_sva.n_fail
                  + i_stepper_top.g_motor[1].i_step_pulse_gen.i_stepper_sva.n_fail
                  + i_stepper_top.g_motor[2].i_step_pulse_gen.i_stepper_sva.n_fail
                  + i_stepper_top.g_motor[3].i_step_pulse_gen.i_stepper_sva.n_fail;
        if (sva_fails != 0) begin
            $display("An assertion on a pulse generator failed");
            $display("Test failures found");
            $fatal(1, "assertion failure");
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout: the stimulus table did not finish in %0d cycles", cycle_limit);
            $display("Test failures found");
            $fatal(1, "timeout");
        end
    end

    initial begin
        int run_sum;
        seed      = 32'h5068;
        rst_n     = 1'b0;
        wr_stb    = 1'b0;
        addr      = '0;
        wdata     = '0;
        rd_stb    = 1'b0;
        endstop   = '0;
        step_prev = '0;
        pos_base  = '0;
        last_rnd  = '0;
        cycle_cnt = 0;
        sva_fails = 0;
        n_entries = 0;
        build_table();
        run_sum = 0;
        for (int i = 0; i < n_entries; i++) begin
            if (tbl_op[i] == op_run) begin
                run_sum += tbl_data[i];
            end
        end
        cycle_limit = 2 * run_sum + 200;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < n_entries; i++) begin
            apply_entry(i);
        end
        repeat (4) @(negedge clk);
        $display("All tests passed!");
        $finish;
    end
endmodule

// ==== testbench/stepper_sva.sv ====
`timescale 1ns/10ps

module stepper_sva (
    input logic                           clk,
    input logic                           rst_n,
    input stepper_pkg::pulse_state_e      state,
    input logic                           step,
    input logic                           hold,
    input logic                           accept,
    input logic                           set_pos,
    input logic [stepper_pkg::data_w-1:0] pos
);
    import stepper_pkg::*;

    int n_fail = 0;

    // a pulse starts from pre or straight from an accepted request
    a_step_entry: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(step) |-> $past(state == ps_pre || accept)
    ) else begin
        n_fail++;
        $error("step rose without coming from pre or an accepted request");
    end

    a_pos_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$stable(pos) |-> $past(set_pos) || ($past(state) == ps_idle && state != ps_idle)
    ) else begin
        n_fail++;
        $error("position changed without a started step or a load");
    end

    // leaving idle means hold was low in that cycle
    a_hold_blocks: assert property (
        @(posedge clk) disable iff (!rst_n)
        $past(state) == ps_idle && state != ps_idle |-> !$past(hold)
    ) else begin
        n_fail++;
        $error("step started while hold was high");
    end
endmodule

bind step_pulse_gen stepper_sva i_stepper_sva (
    .clk      (clk),
    .rst_n    (rst_n),
    .state    (state),
    .step     (step),
    .hold     (hold),
    .accept   (accept),
    .set_pos  (set_pos),
    .pos      (pos)
);

// ==== src/stepper_top.sv ====
`timescale 1ns/10ps

module stepper_top (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               wr_stb,
    input  logic [stepper_pkg::addr_w-1:0]     addr,
    input  logic [stepper_pkg::data_w-1:0]     wdata,
    input  logic                               rd_stb,
    input  logic [stepper_pkg::n_channels-1:0] endstop,
    output logic                               rd_valid,
    output logic [stepper_pkg::data_w-1:0]     rd_data,
    output logic [stepper_pkg::n_motors-1:0]   mot_step,
    output logic [stepper_pkg::n_motors-1:0]   mot_dir,
    output logic [stepper_pkg::n_motors-1:0]   mot_enable
);
    import stepper_pkg::*;

    logic signed [data_w-1:0] speed [n_channels];
    logic [step_bit_w-1:0]    step_bit;
    logic [cnt_w-1:0]         es_timeout;
    motor_cfg_t               motor_cfg [n_motors];
    logic                     load_speeds;
    logic                     unlock;
    logic [data_w-1:0]        pos [n_motors];
    logic [n_channels-1:0]    es_level;
    logic [n_channels-1:0]    es_locked;
    logic [n_channels-1:0]    es_lock_stb;
    logic [n_channels-1:0]    ch_step;
    logic [n_channels-1:0]    ch_dir;
    logic [n_channels-1:0]    ch_abort;
    logic [n_motors-1:0]      step_req;
    logic [n_motors-1:0]      dir_req;
    logic [n_motors-1:0]      hold;

    pulse_cfg_if i_pulse_cfg ();

    stepper_regs i_stepper_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_stb      (wr_stb),
        .addr        (reg_addr_e'(addr)),
        .wdata       (wdata),
        .rd_stb      (rd_stb),
        .pos         (pos),
        .es_level    (es_level),
        .es_locked   (es_locked),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .speed       (speed),
        .step_bit    (step_bit),
        .es_timeout  (es_timeout),
        .motor_cfg   (motor_cfg),
        .load_speeds (load_speeds),
        .unlock      (unlock),
        .cfg_if      (i_pulse_cfg.regs_mp)
    );

    for (genvar c = 0; c < n_channels; c++) begin : g_channel
        speed_integrator i_speed_integrator (
            .clk          (clk),
            .rst_n        (rst_n),
            .speed_staged (speed[c]),
            .load_speeds  (load_speeds),
            .abort        (ch_abort[c]),
            .step_bit     (step_bit),
            .step         (ch_step[c]),
            .dir          (ch_dir[c])
        );

        endstop_filter i_endstop_filter (
            .clk        (clk),
            .rst_n      (rst_n),
            .endstop_in (endstop[c]),
            .es_timeout (es_timeout),
            .unlock     (unlock),
            .level      (es_level[c]),
            .locked     (es_locked[c]),
            .lock_stb   (es_lock_stb[c])
        );
    end

    step_router i_step_router (
        .ch_step     (ch_step),
        .ch_dir      (ch_dir),
        .es_locked   (es_locked),
        .es_lock_stb (es_lock_stb),
        .motor_cfg   (motor_cfg),
        .step_req    (step_req),
        .dir_req     (dir_req),
        .hold        (hold),
        .ch_abort    (ch_abort)
    );

    for (genvar m = 0; m < n_motors; m++) begin : g_motor
        step_pulse_gen i_step_pulse_gen (
            .clk      (clk),
            .rst_n    (rst_n),
            .motor_id (motor_id_w'(m)),
            .step_req (step_req[m]),
            .dir_req  (dir_req[m]),
            .hold     (hold[m]),
            .cfg      (motor_cfg[m]),
            .cfg_if   (i_pulse_cfg.gen_mp),
            .step     (mot_step[m]),
            .dir      (mot_dir[m]),
            .pos      (pos[m])
        );

        assign mot_enable[m] = ~motor_cfg[m].mot_disable;
    end
endmodule

// ==== src/step_pulse_gen.sv ====
`timescale 1ns/10ps

module step_pulse_gen (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [stepper_pkg::motor_id_w-1:0] motor_id,
    input  logic                               step_req,
    input  logic                               dir_req,
    input  logic                               hold,
    input  stepper_pkg::motor_cfg_t            cfg,
    pulse_cfg_if.gen_mp                        cfg_if,
    output logic                               step,
    output logic                               dir,
    output logic [stepper_pkg::data_w-1:0]     pos
);
    import stepper_pkg::*;

    pulse_state_e     state;
    logic [cnt_w-1:0] cnt;
    logic [cnt_w-1:0] pulse_len;
    logic             dir_eff;
    logic             accept;
    logic             set_pos;

    assign pulse_len = (cfg_if.pulse_n == '0) ? cnt_w'(1) : cfg_if.pulse_n;
    assign dir_eff   = dir_req ^ cfg.invert_dir;
    assign accept    = (state == ps_idle) && step_req && !hold;
    assign set_pos   = cfg_if.set_pos[motor_id];
    assign step      = (state == ps_pulse);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pos <= '0;
        end else if (set_pos) begin
            pos <= cfg_if.pos_val;
        end else if (accept) begin
            pos <= dir_eff ? pos - 1'b1 : pos + 1'b1;
        end
    end

    // cnt holds remaining cycles minus one in the current phase
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ps_idle;
            cnt   <= '0;
            dir   <= 1'b0;
        end else begin
            case (state)
                ps_idle: begin
                    if (accept) begin
                        dir <= dir_eff;
                        if (cfg_if.pre_n != '0) begin
                            state <= ps_pre;
                            cnt   <= cfg_if.pre_n - 1'b1;
                        end else begin
                            state <= ps_pulse;
                            cnt   <= pulse_len - 1'b1;
                        end
                    end
                end
                ps_pre: begin
                    if (cnt == '0) begin
                        state <= ps_pulse;
                        cnt   <= pulse_len - 1'b1;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                ps_pulse: begin
                    if (cnt != '0) begin
                        cnt <= cnt - 1'b1;
                    end else if (cfg_if.post_n != '0) begin
                        state <= ps_post;
                        cnt   <= cfg_if.post_n - 1'b1;
                    end else begin
                        state <= ps_idle;
                    end
                end
                default: begin
                    if (cnt == '0) begin
                        state <= ps_idle;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
            endcase
        end
    end
endmodule

// ==== src/step_router.sv ====
`timescale 1ns/10ps

module step_router (
    input  logic [stepper_pkg::n_channels-1:0] ch_step,
    input  logic [stepper_pkg::n_channels-1:0] ch_dir,
    input  logic [stepper_pkg::n_channels-1:0] es_locked,
    input  logic [stepper_pkg::n_channels-1:0] es_lock_stb,
    input  stepper_pkg::motor_cfg_t            motor_cfg [stepper_pkg::n_motors],
    output logic [stepper_pkg::n_motors-1:0]   step_req,
    output logic [stepper_pkg::n_motors-1:0]   dir_req,
    output logic [stepper_pkg::n_motors-1:0]   hold,
    output logic [stepper_pkg::n_channels-1:0] ch_abort
);
    import stepper_pkg::*;

    always_comb begin
        ch_abort = '0;
        for (int m = 0; m < n_motors; m++) begin
            step_req[m] = ch_step[motor_cfg[m].spd_sel] & motor_cfg[m].step_en;
            dir_req[m]  = ch_dir[motor_cfg[m].spd_sel];
            hold[m]     = es_locked[motor_cfg[m].es_sel];
            // lock strobe kills the speed channel this motor follows
            if (motor_cfg[m].es_abort_en && es_lock_stb[motor_cfg[m].es_sel]) begin
                ch_abort[motor_cfg[m].spd_sel] = 1'b1;
            end
        end
    end
endmodule

// ==== src/endstop_filter.sv ====
`timescale 1ns/10ps

module endstop_filter (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          endstop_in,
    input  logic [stepper_pkg::cnt_w-1:0] es_timeout,
    input  logic                          unlock,
    output logic                          level,
    output logic                          locked,
    output logic                          lock_stb
);
    import stepper_pkg::*;

    logic             meta;
    logic [cnt_w-1:0] cnt;
    logic [cnt_w-1:0] cnt_nxt;
    logic             hit;

    // consecutive high cycles
    always_comb begin
        if (!level) begin
            cnt_nxt = '0;
        end else if (&cnt) begin
            cnt_nxt = cnt;  // saturate
        end else begin
            cnt_nxt = cnt + 1'b1;
        end
    end

    // a timeout of zero never locks
    assign hit = level && !locked && (cnt_nxt == es_timeout);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            meta     <= 1'b0;
            level    <= 1'b0;
            cnt      <= '0;
            locked   <= 1'b0;
            lock_stb <= 1'b0;
        end else begin
            meta     <= endstop_in;
            level    <= meta;
            cnt      <= cnt_nxt;
            lock_stb <= hit;
            if (hit) begin
                locked <= 1'b1;
            end else if (unlock && !level) begin
                locked <= 1'b0;
            end
        end
    end
endmodule

// ==== src/speed_integrator.sv ====
`timescale 1ns/10ps

module speed_integrator (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic signed [stepper_pkg::data_w-1:0] speed_staged,
    input  logic                                  load_speeds,
    input  logic                                  abort,
    input  logic [stepper_pkg::step_bit_w-1:0]    step_bit,
    output logic                                  step,
    output logic                                  dir
);
    import stepper_pkg::*;

    logic signed [data_w-1:0] speed_active;
    logic [data_w-1:0]        acc;
    logic [data_w-1:0]        acc_nxt;

    assign acc_nxt = acc + speed_active;
    assign dir     = speed_active[data_w-1];  // sign of speed

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            speed_active <= '0;
            acc          <= '0;
            step         <= 1'b0;
        end else begin
            acc  <= acc_nxt;
            step <= acc_nxt[step_bit] ^ acc[step_bit];  // either edge of the bit
            if (abort) begin
                speed_active <= '0;
            end else if (load_speeds) begin
                speed_active <= speed_staged;
            end
        end
    end
endmodule

// ==== src/stepper_regs.sv ====
`timescale 1ns/10ps

module stepper_regs (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  wr_stb,
    input  stepper_pkg::reg_addr_e                addr,
    input  logic [stepper_pkg::data_w-1:0]        wdata,
    input  logic                                  rd_stb,
    input  logic [stepper_pkg::data_w-1:0]        pos [stepper_pkg::n_motors],
    input  logic [stepper_pkg::n_channels-1:0]    es_level,
    input  logic [stepper_pkg::n_channels-1:0]    es_locked,
    output logic                                  rd_valid,
    output logic [stepper_pkg::data_w-1:0]        rd_data,
    output logic signed [stepper_pkg::data_w-1:0] speed [stepper_pkg::n_channels],
    output logic [stepper_pkg::step_bit_w-1:0]    step_bit,
    output logic [stepper_pkg::cnt_w-1:0]         es_timeout,
    output stepper_pkg::motor_cfg_t               motor_cfg [stepper_pkg::n_motors],
    output logic                                  load_speeds,
    output logic                                  unlock,
    pulse_cfg_if.regs_mp                          cfg_if
);
    import stepper_pkg::*;

    logic [data_w-1:0] loopback;
    logic              cmd_wr;
    logic [data_w-1:0] rd_mux;

    assign cmd_wr = wr_stb && (addr == addr_cmd);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < n_channels; i++) begin
                speed[i] <= '0;
            end
            for (int i = 0; i < n_motors; i++) begin
                motor_cfg[i] <= '0;
            end
            step_bit       <= '0;
            es_timeout     <= '0;
            loopback       <= '0;
            cfg_if.pre_n   <= '0;
            cfg_if.pulse_n <= '0;
            cfg_if.post_n  <= '0;
            cfg_if.pos_val <= '0;
        end else if (wr_stb) begin
            for (int i = 0; i < n_channels; i++) begin
                if (addr == reg_addr_e'(addr_speed0 + i)) begin
                    speed[i] <= signed'(wdata);
                end
            end
            for (int i = 0; i < n_motors; i++) begin
                if (addr == reg_addr_e'(addr_motor_cfg0 + i)) begin
                    motor_cfg[i] <= motor_cfg_t'(wdata[$bits(motor_cfg_t)-1:0]);
                end
            end
            case (addr)
                addr_step_bit:   step_bit       <= wdata[step_bit_w-1:0];
                addr_pre:        cfg_if.pre_n   <= wdata[cnt_w-1:0];
                addr_pulse:      cfg_if.pulse_n <= wdata[cnt_w-1:0];
                addr_post:       cfg_if.post_n  <= wdata[cnt_w-1:0];
                addr_pos_val:    cfg_if.pos_val <= wdata;
                addr_es_timeout: es_timeout     <= wdata[cnt_w-1:0];
                addr_loopback:   loopback       <= wdata;
                default: ;
            endcase
        end
    end

    // command bits become strobes one cycle after the write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            load_speeds    <= 1'b0;
            unlock         <= 1'b0;
            cfg_if.set_pos <= '0;
        end else begin
            load_speeds    <= cmd_wr && wdata[0];
            cfg_if.set_pos <= (cmd_wr && wdata[1]) ? wdata[8 +: n_motors] : '0;
            unlock         <= cmd_wr && wdata[2];
        end
    end

    always_comb begin
        rd_mux = '0;  // unknown addresses read zero
        for (int i = 0; i < n_channels; i++) begin
            if (addr == reg_addr_e'(addr_speed0 + i)) begin
                rd_mux = speed[i];
            end
        end
        for (int i = 0; i < n_motors; i++) begin
            if (addr == reg_addr_e'(addr_motor_cfg0 + i)) begin
                rd_mux = data_w'(motor_cfg[i]);
            end
            if (addr == reg_addr_e'(addr_pos0 + i)) begin
                rd_mux = pos[i];
            end
        end
        case (addr)
            addr_step_bit:   rd_mux = data_w'(step_bit);
            addr_pre:        rd_mux = data_w'(cfg_if.pre_n);
            addr_pulse:      rd_mux = data_w'(cfg_if.pulse_n);
            addr_post:       rd_mux = data_w'(cfg_if.post_n);
            addr_pos_val:    rd_mux = cfg_if.pos_val;
            addr_es_timeout: rd_mux = data_w'(es_timeout);
            addr_es_status:  rd_mux = data_w'({es_locked, es_level});
            addr_loopback:   rd_mux = loopback;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_stb;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_stb) begin
            rd_data <= rd_mux;
        end
    end
endmodule

// ==== src/pulse_cfg_if.sv ====
`timescale 1ns/10ps

interface pulse_cfg_if;
    import stepper_pkg::*;

    logic [cnt_w-1:0]    pre_n;
    logic [cnt_w-1:0]    pulse_n;
    logic [cnt_w-1:0]    post_n;
    logic [data_w-1:0]   pos_val;
    logic [n_motors-1:0] set_pos;  // one-cycle strobe per motor

    modport regs_mp (
        output pre_n,
        output pulse_n,
        output post_n,
        output pos_val,
        output set_pos
    );

    modport gen_mp (
        input pre_n,
        input pulse_n,
        input post_n,
        input pos_val,
        input set_pos
    );
endinterface

// ==== src/stepper_pkg.sv ====
package stepper_pkg;

    localparam int n_motors   = 4;
    localparam int n_channels = 4;
    localparam int data_w     = 32;
    localparam int addr_w     = 8;
    localparam int sel_w      = 2;
    localparam int motor_id_w = $clog2(n_motors);
    localparam int cnt_w      = 16;  // pre/pulse/post and endstop timeout
    localparam int step_bit_w = 5;

    typedef enum logic [addr_w-1:0] {
        addr_speed0     = 8'h00,
        addr_speed1     = 8'h01,
        addr_speed2     = 8'h02,
        addr_speed3     = 8'h03,
        addr_step_bit   = 8'h04,
        addr_pre        = 8'h05,
        addr_pulse      = 8'h06,
        addr_post       = 8'h07,
        addr_pos_val    = 8'h08,
        addr_es_timeout = 8'h09,
        addr_motor_cfg0 = 8'h10,
        addr_motor_cfg1 = 8'h11,
        addr_motor_cfg2 = 8'h12,
        addr_motor_cfg3 = 8'h13,
        addr_cmd        = 8'h20,  // write only
        addr_pos0       = 8'h30,
        addr_pos1       = 8'h31,
        addr_pos2       = 8'h32,
        addr_pos3       = 8'h33,
        addr_es_status  = 8'h34,
        addr_loopback   = 8'h3F
    } reg_addr_e;

    typedef enum logic [1:0] {
        ps_idle,
        ps_pre,
        ps_pulse,
        ps_post
    } pulse_state_e;

    typedef struct packed {
        logic             mot_disable;  // bit 7, drives enable low
        logic             step_en;
        logic             invert_dir;
        logic             es_abort_en;
        logic [sel_w-1:0] es_sel;
        logic [sel_w-1:0] spd_sel;      // bits 1:0
    } motor_cfg_t;

endpackage
